// File: Makefile
# Verilator build, run and lint for the VGA test pattern project.

VERILATOR  ?= verilator
TOP        := vga_tb
RTL_TOP    := vga_top
FILE_LIST  := list.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing

SOURCES := $(wildcard design/*.sv design/*.svh verification/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/$(TOP)

$(BUILD_DIR)/$(TOP): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)

// File: design/pixel_fifo.sv
// ----------------------------------------------------------------------
// First-word-fall-through FIFO for any packed payload. The head entry is
// always on out_data; a read pops it when out_vld and out_rdy are high.
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "vga_cfg.svh"

module pixel_fifo #(
    parameter type T = vga_pkg::pixel_t
) (
    input  logic pixel_clk,
    input  logic pixel_rst,
    input  T     in_data,
    input  logic in_vld,
    output logic in_rdy,
    output T     out_data,
    output logic out_vld,
    input  logic out_rdy
);

    localparam int DEPTH = `FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;
    logic          wr_en;
    logic          rd_en;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        next_ptr = (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full     = count == (AW + 1)'(DEPTH);
    assign out_vld  = count != '0;
    assign out_data = mem[rd_ptr];

    // When full, a pop in the same cycle frees the slot being written.
    assign in_rdy = ~full | out_rdy;

    assign wr_en = in_vld & in_rdy;
    assign rd_en = out_vld & out_rdy;

    always_ff @(posedge pixel_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge pixel_clk) begin
        if (pixel_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: design/vga_cfg.svh
// ----------------------------------------------------------------------
// Timing, colour and buffering constants for the 640x480 60 Hz VGA path.
// Include this wherever the counters, colour widths or FIFO depth are used.
// ----------------------------------------------------------------------

`ifndef VGA_CFG_SVH
`define VGA_CFG_SVH

// Horizontal timing in pixel clocks.
`define H_DISPLAY       640
`define H_FRONT_PORCH   16
`define H_SYNC_PULSE    96
`define H_BACK_PORCH    48
`define H_COUNT         800

// Vertical timing in lines.
`define V_DISPLAY       480
`define V_FRONT_PORCH   10
`define V_SYNC_PULSE    2
`define V_BACK_PORCH    33
`define V_COUNT         525

// Counter widths, wide enough for H_COUNT and V_COUNT.
`define H_SIZE          10
`define V_SIZE          10

`define RSIZE           4
`define GSIZE           4
`define BSIZE           4

// Entries between the pattern generator and the sync core.
`define FIFO_DEPTH      16

`endif

// File: design/vga_pattern_gen.sv
// ----------------------------------------------------------------------
// Test pattern source. Emits the active pixels of each frame in raster
// order over a valid/ready link, flagging the first pixel of a frame.
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "vga_cfg.svh"

module vga_pattern_gen (
    input  logic              pixel_clk,
    input  logic              pixel_rst,
    input  vga_pkg::pattern_e pattern_sel,
    input  vga_pkg::rgb_t     fg_color,
    output vga_pkg::pixel_t   pix,
    output logic              pix_vld,
    input  logic              pix_rdy
);

    import vga_pkg::*;

    // Eight vertical bars across the active width.
    localparam int BAR_WIDTH = `H_DISPLAY / 8;

    logic [`H_SIZE-1:0] x;
    logic [`V_SIZE-1:0] y;
    logic               xfer;
    logic               sof;
    logic               x_last;
    logic               y_last;
    logic [2:0]         bar_idx;
    pattern_e           pat_q;
    rgb_t               fg_q;
    pattern_e           pat_cur;
    rgb_t               fg_cur;
    rgb_t               color;

    assign xfer   = pix_vld & pix_rdy;
    assign sof    = (x == '0) && (y == '0);
    assign x_last = x == `H_SIZE'(`H_DISPLAY - 1);
    assign y_last = y == `V_SIZE'(`V_DISPLAY - 1);

    always_ff @(posedge pixel_clk) begin
        if (pixel_rst) begin
            x       <= '0;
            y       <= '0;
            pix_vld <= 1'b0;
            pat_q   <= PAT_BARS;
        end else begin
            pix_vld <= 1'b1;
            if (xfer) begin
                if (x_last) begin
                    x <= '0;
                    y <= y_last ? '0 : y + 1'b1;
                end else begin
                    x <= x + 1'b1;
                end
                if (sof) begin
                    pat_q <= pattern_sel;
                end
            end
        end
    end

    always_ff @(posedge pixel_clk) begin
        if (xfer && sof) begin
            fg_q <= fg_color;
        end
    end

    // The first pixel of a frame sees the live inputs, the rest of the
    // frame uses the copy taken when that pixel went out.
    assign pat_cur = sof ? pattern_sel : pat_q;
    assign fg_cur  = sof ? fg_color : fg_q;

    assign bar_idx = 3'(x / BAR_WIDTH);

    always_comb begin
        color = '0;
        case (pat_cur)
            PAT_BARS: begin
                color.r = bar_idx[2] ? '1 : '0;
                color.g = bar_idx[1] ? '1 : '0;
                color.b = bar_idx[0] ? '1 : '0;
            end
            PAT_CHECKER: begin
                color = (x[5] ^ y[5]) ? '1 : '0;
            end
            PAT_GRADIENT: begin
                color.r = x[9:6];
                color.g = y[8:5];
                color.b = x[5:2] ^ y[5:2];
            end
            default: begin
                color = fg_cur;
            end
        endcase
    end

    assign pix.sof   = sof;
    assign pix.color = color;

endmodule

// File: design/vga_pkg.sv
// ----------------------------------------------------------------------
// Shared types for the VGA pixel pipeline.
// Compile before any module that names vga_pkg.
// ----------------------------------------------------------------------

`include "vga_cfg.svh"

package vga_pkg;

    // One displayed colour, red in the top bits.
    typedef struct packed {
        logic [`RSIZE-1:0] r;
        logic [`GSIZE-1:0] g;
        logic [`BSIZE-1:0] b;
    } rgb_t;

    // A pixel on the stream. The start-of-frame flag sits above the colour.
    typedef struct packed {
        logic sof;
        rgb_t color;
    } pixel_t;

    // Test patterns the generator can produce.
    typedef enum logic [1:0] {
        PAT_BARS     = 2'd0,
        PAT_CHECKER  = 2'd1,
        PAT_GRADIENT = 2'd2,
        PAT_SOLID    = 2'd3
    } pattern_e;

endpackage

// File: design/vga_sync.sv
// ----------------------------------------------------------------------
// VGA timing core. Runs the h/v counters, drives registered hsync, vsync
// and RGB, and pulls pixels from the stream once it has locked to a frame.
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "vga_cfg.svh"

module vga_sync (
    input  logic              pixel_clk,
    input  logic              pixel_rst,
    input  vga_pkg::pixel_t   src_pix,
    input  logic              src_vld,
    output logic              src_rdy,
    output logic [`RSIZE-1:0] vga_r,
    output logic [`GSIZE-1:0] vga_g,
    output logic [`BSIZE-1:0] vga_b,
    output logic              vga_hsync,
    output logic              vga_vsync
);

    typedef enum logic {
        S_SYNC = 1'b0,
        S_DISP = 1'b1
    } state_e;

    localparam int H_SYNC_START = `H_DISPLAY + `H_FRONT_PORCH;
    localparam int H_SYNC_END   = H_SYNC_START + `H_SYNC_PULSE;
    localparam int V_SYNC_START = `V_DISPLAY + `V_FRONT_PORCH;
    localparam int V_SYNC_END   = V_SYNC_START + `V_SYNC_PULSE;

    state_e             state;
    logic [`H_SIZE-1:0] h_counter;
    logic [`V_SIZE-1:0] v_counter;
    logic               h_wrap;
    logic               v_wrap;
    logic               scan_end;
    logic               disp_end;
    logic               h_video_on;
    logic               v_video_on;
    logic               video_on;
    logic               head_sof;
    logic               show_pixel;

    assign h_wrap   = h_counter == `H_SIZE'(`H_COUNT - 1);
    assign v_wrap   = v_counter == `V_SIZE'(`V_COUNT - 1);
    assign scan_end = h_wrap & v_wrap;

    always_ff @(posedge pixel_clk) begin
        if (pixel_rst) begin
            h_counter <= '0;
            v_counter <= '0;
        end else begin
            h_counter <= h_wrap ? '0 : h_counter + 1'b1;
            if (h_wrap) begin
                v_counter <= v_wrap ? '0 : v_counter + 1'b1;
            end
        end
    end

    assign h_video_on = h_counter < `H_SIZE'(`H_DISPLAY);
    assign v_video_on = v_counter < `V_SIZE'(`V_DISPLAY);
    assign video_on   = h_video_on & v_video_on;

    // Last active pixel of the frame.
    assign disp_end = (h_counter == `H_SIZE'(`H_DISPLAY - 1)) &&
                      (v_counter == `V_SIZE'(`V_DISPLAY - 1));

    assign head_sof = src_vld & src_pix.sof;

    // Lock only when a new frame is waiting at the head as the scan wraps.
    always_ff @(posedge pixel_clk) begin
        if (pixel_rst) begin
            state <= S_SYNC;
        end else begin
            case (state)
                S_SYNC: begin
                    if (scan_end && head_sof) begin
                        state <= S_DISP;
                    end
                end
                default: begin
                    if (disp_end) begin
                        state <= S_SYNC;
                    end
                end
            endcase
        end
    end

    // While unlocked, stray pixels from a partial frame are thrown away
    // until a start-of-frame pixel reaches the head.
    always_comb begin
        case (state)
            S_SYNC:  src_rdy = ~src_pix.sof;
            default: src_rdy = video_on;
        endcase
    end

    // Blank everything outside the active area, and whenever no pixel is
    // available during active video.
    assign show_pixel = (state == S_DISP) & video_on & src_vld;

    always_ff @(posedge pixel_clk) begin
        vga_hsync <= (h_counter < `H_SIZE'(H_SYNC_START)) ||
                     (h_counter >= `H_SIZE'(H_SYNC_END));
        vga_vsync <= (v_counter < `V_SIZE'(V_SYNC_START)) ||
                     (v_counter >= `V_SIZE'(V_SYNC_END));
        if (show_pixel) begin
            vga_r <= src_pix.color.r;
            vga_g <= src_pix.color.g;
            vga_b <= src_pix.color.b;
        end else begin
            vga_r <= '0;
            vga_g <= '0;
            vga_b <= '0;
        end
    end

endmodule

// File: design/vga_top.sv
// ----------------------------------------------------------------------
// VGA test pattern top level. Chains the pattern generator, the pixel
// FIFO and the sync core; drive pattern_sel and fg_color to pick output.
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "vga_cfg.svh"

module vga_top (
    input  logic              pixel_clk,
    input  logic              pixel_rst,
    input  vga_pkg::pattern_e pattern_sel,
    input  vga_pkg::rgb_t     fg_color,
    output logic [`RSIZE-1:0] vga_r,
    output logic [`GSIZE-1:0] vga_g,
    output logic [`BSIZE-1:0] vga_b,
    output logic              vga_hsync,
    output logic              vga_vsync
);

    import vga_pkg::*;

    // Generator to FIFO.
    pixel_t gen_pix;
    logic   gen_vld;
    logic   gen_rdy;

    // FIFO to sync core.
    pixel_t head_pix;
    logic   head_vld;
    logic   head_rdy;

    vga_pattern_gen u_pattern_gen (
        .pixel_clk   (pixel_clk),
        .pixel_rst   (pixel_rst),
        .pattern_sel (pattern_sel),
        .fg_color    (fg_color),
        .pix         (gen_pix),
        .pix_vld     (gen_vld),
        .pix_rdy     (gen_rdy)
    );

    pixel_fifo #(
        .T (pixel_t)
    ) u_pixel_fifo (
        .pixel_clk (pixel_clk),
        .pixel_rst (pixel_rst),
        .in_data   (gen_pix),
        .in_vld    (gen_vld),
        .in_rdy    (gen_rdy),
        .out_data  (head_pix),
        .out_vld   (head_vld),
        .out_rdy   (head_rdy)
    );

    vga_sync u_vga_sync (
        .pixel_clk (pixel_clk),
        .pixel_rst (pixel_rst),
        .src_pix   (head_pix),
        .src_vld   (head_vld),
        .src_rdy   (head_rdy),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync)
    );

endmodule

// File: list.f
+incdir+design
design/vga_pkg.sv
design/pixel_fifo.sv
design/vga_pattern_gen.sv
design/vga_sync.sv
design/vga_top.sv
verification/vga_tb.sv

// File: verification/vga_tb.sv
// ----------------------------------------------------------------------
// Testbench for the VGA test pattern top level. Runs five frames, steps
// the pattern through bars, checker, gradient and solid colour, and checks
// sync timing and every pixel against a model of the display timing.
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "vga_cfg.svh"

module vga_tb;

    import vga_pkg::*;

    localparam int H_SYNC_START   = `H_DISPLAY + `H_FRONT_PORCH;
    localparam int H_SYNC_END     = H_SYNC_START + `H_SYNC_PULSE;
    localparam int V_SYNC_START   = `V_DISPLAY + `V_FRONT_PORCH;
    localparam int V_SYNC_END     = V_SYNC_START + `V_SYNC_PULSE;
    localparam int FRAME_CYCLES   = `H_COUNT * `V_COUNT;
    localparam int TIMEOUT_CYCLES = 6 * FRAME_CYCLES + 1000;

    logic       pixel_clk = 1'b0;
    logic       pixel_rst;
    pattern_e   pattern_sel;
    rgb_t       fg_color;
    logic [3:0] vga_r;
    logic [3:0] vga_g;
    logic [3:0] vga_b;
    logic       vga_hsync;
    logic       vga_vsync;

    // Reference raster position and its copy one cycle later.
    int   tb_h;
    int   tb_v;
    int   tb_frame;
    int   d_h;
    int   d_v;
    int   d_frame;
    logic checking;

    logic exp_hsync;
    logic exp_vsync;
    logic exp_active;
    rgb_t exp_color;

    logic vsync_q;
    logic seen_vsync_fall;
    int   vsync_gap;
    int   cycle_count = 0;

    rgb_t fg_first;
    rgb_t fg_second;
    int   switch_v;
    int   switch_h;

    vga_top u_vga_top (
        .pixel_clk   (pixel_clk),
        .pixel_rst   (pixel_rst),
        .pattern_sel (pattern_sel),
        .fg_color    (fg_color),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hsync   (vga_hsync),
        .vga_vsync   (vga_vsync)
    );

    always #5 pixel_clk = ~pixel_clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string what, input logic [11:0] expected,
                                   input logic [11:0] actual);
        fail_run($sformatf("** Error at %0t: %s expected %03h, got %03h",
                           $time, what, expected, actual));
    endtask

    // Returns 1 ns after the edge that moves the reference raster onto (frame, v, h).
    task automatic wait_until_position(input int frame, input int v, input int h);
        @(posedge pixel_clk);
        #1;
        while (!(tb_frame == frame && tb_v == v && tb_h == h)) begin
            @(posedge pixel_clk);
            #1;
        end
    endtask

    // Picture expected in a given displayed frame at active pixel (x, y).
    function automatic rgb_t pattern_color(input int frame, input int x, input int y);
        logic [9:0] xb;
        logic [9:0] yb;
        logic [2:0] bar;
        xb  = 10'(x);
        yb  = 10'(y);
        bar = 3'(x / (`H_DISPLAY / 8));
        pattern_color = '0;
        case (frame)
            1: begin
                pattern_color.r = bar[2] ? 4'hF : 4'h0;
                pattern_color.g = bar[1] ? 4'hF : 4'h0;
                pattern_color.b = bar[0] ? 4'hF : 4'h0;
            end
            2: pattern_color = (xb[5] ^ yb[5]) ? 12'hFFF : 12'h000;
            3: begin
                pattern_color.r = xb[9:6];
                pattern_color.g = yb[8:5];
                pattern_color.b = xb[5:2] ^ yb[5:2];
            end
            default: pattern_color = fg_first;
        endcase
    endfunction

    always @(posedge pixel_clk) begin
        if (pixel_rst) begin
            tb_h     <= 0;
            tb_v     <= 0;
            tb_frame <= 0;
        end else if (tb_h == `H_COUNT - 1) begin
            tb_h <= 0;
            if (tb_v == `V_COUNT - 1) begin
                tb_v     <= 0;
                tb_frame <= tb_frame + 1;
            end else begin
                tb_v <= tb_v + 1;
            end
        end else begin
            tb_h <= tb_h + 1;
        end
    end

    // The sync outputs are registered, so they trail the raster by a cycle.
    always @(posedge pixel_clk) begin
        d_h      <= tb_h;
        d_v      <= tb_v;
        d_frame  <= tb_frame;
        checking <= ~pixel_rst;
    end

    always_comb begin
        exp_hsync  = !((d_h >= H_SYNC_START) && (d_h < H_SYNC_END));
        exp_vsync  = !((d_v >= V_SYNC_START) && (d_v < V_SYNC_END));
        exp_active = (d_h < `H_DISPLAY) && (d_v < `V_DISPLAY);
        // Frame 0 stays black while the sync core waits for a frame start.
        if (exp_active && d_frame >= 1) begin
            exp_color = pattern_color(d_frame, d_h, d_v);
        end else begin
            exp_color = '0;
        end
    end

    always @(posedge pixel_clk) begin
        if (!checking) begin
            vsync_q         <= 1'b1;
            vsync_gap       <= 0;
            seen_vsync_fall <= 1'b0;
        end else begin
            vsync_q <= vga_vsync;
            if (vsync_q && !vga_vsync) begin
                vsync_gap       <= 1;
                seen_vsync_fall <= 1'b1;
            end else begin
                vsync_gap <= vsync_gap + 1;
            end
        end
    end

    always @(posedge pixel_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            fail_run("Timeout: the run did not reach the end of frame 4");
        end
    end

    assert property (@(posedge pixel_clk) checking |-> (vga_hsync == exp_hsync))
        else report_mismatch("hsync", 12'($sampled(exp_hsync)), 12'($sampled(vga_hsync)));

    assert property (@(posedge pixel_clk) checking |-> (vga_vsync == exp_vsync))
        else report_mismatch("vsync", 12'($sampled(exp_vsync)), 12'($sampled(vga_vsync)));

    assert property (@(posedge pixel_clk) checking |-> ({vga_r, vga_g, vga_b} == exp_color))
        else report_mismatch("rgb", $sampled(exp_color), $sampled({vga_r, vga_g, vga_b}));

    assert property (@(posedge pixel_clk)
                     (checking && seen_vsync_fall && vsync_q && !vga_vsync) |->
                     (vsync_gap == FRAME_CYCLES))
        else fail_run($sformatf("** Error at %0t: frame period expected %0d, got %0d",
                                $time, FRAME_CYCLES, $sampled(vsync_gap)));

    initial begin
        void'($urandom(32005));
        pixel_rst   = 1'b1;
        pattern_sel = PAT_BARS;
        fg_color    = '0;
        fg_first    = rgb_t'(12'($urandom));
        fg_second   = rgb_t'(~12'(fg_first));
        // The switch stays clear of the last 32 active pixels of frame 2.
        switch_v    = int'($urandom % (`V_DISPLAY - 1));
        switch_h    = int'($urandom % `H_COUNT);

        repeat (5) @(posedge pixel_clk);
        #1;
        pixel_rst = 1'b0;

        wait_until_position(1, 0, 0);
        pattern_sel = PAT_CHECKER;

        wait_until_position(2, switch_v, switch_h);
        pattern_sel = PAT_GRADIENT;

        wait_until_position(3, 100, 0);
        pattern_sel = PAT_SOLID;
        fg_color    = fg_first;

        // Frame 4 has already been latched by the generator at this point.
        wait_until_position(3, 500, 0);
        fg_color = fg_second;

        // The last output of frame 4 is compared on the edge that reaches
        // this position, before any pixel of frame 5 is shown.
        wait_until_position(5, 0, 1);
        $display("Everything OK");
        $finish;
    end

endmodule
